//--- common/id_pkg.sv
// ----------------------------------------------------------
// Decode stage package
// Fetch and issue entry types, functional unit encoding,
// exception record, opcode and cause constants
// ----------------------------------------------------------
`default_nettype none

package id_pkg;

  // One word as delivered by the fetch unit
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] instr;
    logic        fetch_fault;
  } fetch_entry_t;

  typedef enum logic [2:0] {
    FU_NONE   = 3'd0,
    FU_ALU    = 3'd1,
    FU_BRANCH = 3'd2,
    FU_LOAD   = 3'd3,
    FU_STORE  = 3'd4,
    FU_CSR    = 3'd5
  } fu_t;

  typedef struct packed {
    logic       valid;
    logic [3:0] cause;
  } exception_t;

  // Decoded instruction as handed to issue
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] orig_instr;
    fu_t         fu;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] imm;
    logic        is_compressed;
    logic        is_ctrl_flow;
    exception_t  ex;
  } issue_entry_t;

  // ----------------------------------------------------------
  // Exception causes
  // ----------------------------------------------------------
  localparam logic [3:0] CAUSE_FETCH_FAULT = 4'd1;
  localparam logic [3:0] CAUSE_ILLEGAL     = 4'd2;
  localparam logic [3:0] CAUSE_BREAKPOINT  = 4'd3;
  localparam logic [3:0] CAUSE_ECALL_M     = 4'd11;

  // ----------------------------------------------------------
  // RV32I major opcodes
  // ----------------------------------------------------------
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

endpackage

`default_nettype wire

//--- decode/compressed_expander.sv
// ----------------------------------------------------------
// RVC expander
// Maps the supported 16-bit encodings onto their RV32I
// equivalents and flags everything else as illegal.
// Full-width words pass straight through
// ----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module compressed_expander (
  input  logic [31:0] instr_i,
  output logic [31:0] instr_o,
  output logic        is_compressed_o,
  output logic        illegal_o
);

  import id_pkg::*;

  logic [11:0] imm_i6;
  logic [11:0] mem_off;
  logic [20:0] j_off;
  logic [12:0] b_off;
  logic [4:0]  rd_p;
  logic [4:0]  rs2_p;

  // Compressed register fields address x8 to x15
  assign rd_p  = {2'b01, instr_i[4:2]};
  assign rs2_p = {2'b01, instr_i[9:7]};

  // Sign-extended 6-bit immediate of C.ADDI and C.LI
  assign imm_i6  = {{6{instr_i[12]}}, instr_i[12], instr_i[6:2]};
  // C.LW and C.SW word offset
  assign mem_off = {5'b0, instr_i[5], instr_i[12:10], instr_i[6], 2'b00};
  assign j_off   = {{9{instr_i[12]}}, instr_i[12], instr_i[8], instr_i[10:9], instr_i[6],
                    instr_i[7], instr_i[2], instr_i[11], instr_i[5:3], 1'b0};
  assign b_off   = {{4{instr_i[12]}}, instr_i[12], instr_i[6:5], instr_i[2],
                    instr_i[11:10], instr_i[4:3], 1'b0};

  assign is_compressed_o = (instr_i[1:0] != 2'b11);

  always_comb begin
    instr_o   = instr_i;
    illegal_o = 1'b0;
    if (is_compressed_o) begin
      unique case ({instr_i[15:13], instr_i[1:0]})
        // C.LW
        5'b010_00: begin
          instr_o = {mem_off, rs2_p, 3'b010, rd_p, OPC_LOAD};
        end
        // C.SW
        5'b110_00: begin
          instr_o = {mem_off[11:5], rd_p, rs2_p, 3'b010, mem_off[4:0], OPC_STORE};
        end
        // C.ADDI and C.NOP
        5'b000_01: begin
          instr_o = {imm_i6, instr_i[11:7], 3'b000, instr_i[11:7], OPC_OP_IMM};
        end
        // C.LI
        5'b010_01: begin
          instr_o = {imm_i6, 5'd0, 3'b000, instr_i[11:7], OPC_OP_IMM};
        end
        // C.LUI, where rd x2 would be C.ADDI16SP
        5'b011_01: begin
          instr_o = {{14{instr_i[12]}}, instr_i[12], instr_i[6:2], instr_i[11:7], OPC_LUI};
          if (instr_i[11:7] == 5'd2 || {instr_i[12], instr_i[6:2]} == 6'd0) begin
            illegal_o = 1'b1;
          end
        end
        // C.J
        5'b101_01: begin
          instr_o = {j_off[20], j_off[10:1], j_off[11], j_off[19:12], 5'd0, OPC_JAL};
        end
        // C.BEQZ and C.BNEZ
        5'b110_01, 5'b111_01: begin
          instr_o = {b_off[12], b_off[10:5], 5'd0, rs2_p, 2'b00, instr_i[13],
                     b_off[4:1], b_off[11], OPC_BRANCH};
        end
        5'b100_10: begin
          if (!instr_i[12]) begin
            if (instr_i[6:2] == 5'd0) begin
              // C.JR with rs1 x0 is reserved
              instr_o   = {12'd0, instr_i[11:7], 3'b000, 5'd0, OPC_JALR};
              illegal_o = (instr_i[11:7] == 5'd0);
            end else begin
              // C.MV
              instr_o = {7'd0, instr_i[6:2], 5'd0, 3'b000, instr_i[11:7], OPC_OP};
            end
          end else if (instr_i[6:2] != 5'd0) begin
            // C.ADD
            instr_o = {7'd0, instr_i[6:2], instr_i[11:7], 3'b000, instr_i[11:7], OPC_OP};
          end else begin
            // C.EBREAK and C.JALR are not supported
            illegal_o = 1'b1;
          end
        end
        // Covers the all-zero halfword and every unsupported encoding
        default: begin
          illegal_o = 1'b1;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- decode/instr_decoder.sv
// ----------------------------------------------------------
// RV32I decoder
// Turns an expanded instruction into an issue entry with
// functional unit, register fields, immediate and exception
// ----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module instr_decoder (
  input  logic                [31:0] pc_i,
  input  logic                [31:0] instr_i,
  input  logic                [31:0] orig_instr_i,
  input  logic                       is_compressed_i,
  input  logic                       illegal_i,
  input  logic                       fetch_fault_i,
  output id_pkg::issue_entry_t       entry_o
);

  import id_pkg::*;

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] imm_j;
  logic        illegal;
  logic        is_ecall;
  logic        is_ebreak;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_u = {instr_i[31:12], 12'd0};
  assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

  always_comb begin
    entry_o               = '0;
    entry_o.pc            = pc_i;
    entry_o.orig_instr    = orig_instr_i;
    entry_o.fu            = FU_NONE;
    entry_o.is_compressed = is_compressed_i;
    illegal               = 1'b0;
    is_ecall              = 1'b0;
    is_ebreak             = 1'b0;

    unique case (opcode)
      OPC_LUI, OPC_AUIPC: begin
        entry_o.fu  = FU_ALU;
        entry_o.rd  = instr_i[11:7];
        entry_o.imm = imm_u;
      end
      OPC_JAL: begin
        entry_o.fu           = FU_BRANCH;
        entry_o.rd           = instr_i[11:7];
        entry_o.imm          = imm_j;
        entry_o.is_ctrl_flow = 1'b1;
      end
      OPC_JALR: begin
        entry_o.fu           = FU_BRANCH;
        entry_o.rd           = instr_i[11:7];
        entry_o.rs1          = instr_i[19:15];
        entry_o.imm          = imm_i;
        entry_o.is_ctrl_flow = 1'b1;
        illegal              = (funct3 != 3'b000);
      end
      OPC_BRANCH: begin
        entry_o.fu           = FU_BRANCH;
        entry_o.rs1          = instr_i[19:15];
        entry_o.rs2          = instr_i[24:20];
        entry_o.imm          = imm_b;
        entry_o.is_ctrl_flow = 1'b1;
        illegal              = (funct3 == 3'b010) || (funct3 == 3'b011);
      end
      OPC_LOAD: begin
        entry_o.fu  = FU_LOAD;
        entry_o.rd  = instr_i[11:7];
        entry_o.rs1 = instr_i[19:15];
        entry_o.imm = imm_i;
        illegal     = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
      end
      OPC_STORE: begin
        entry_o.fu  = FU_STORE;
        entry_o.rs1 = instr_i[19:15];
        entry_o.rs2 = instr_i[24:20];
        entry_o.imm = imm_s;
        illegal     = (funct3[2] || funct3 == 3'b011);
      end
      OPC_OP_IMM: begin
        entry_o.fu  = FU_ALU;
        entry_o.rd  = instr_i[11:7];
        entry_o.rs1 = instr_i[19:15];
        entry_o.imm = imm_i;
        // Shift amounts only allow the SRAI variant in the upper bits
        if (funct3 == 3'b001) begin
          illegal = (funct7 != 7'd0);
        end else if (funct3 == 3'b101) begin
          illegal = (funct7 != 7'd0) && (funct7 != 7'b0100000);
        end
      end
      OPC_OP: begin
        entry_o.fu  = FU_ALU;
        entry_o.rd  = instr_i[11:7];
        entry_o.rs1 = instr_i[19:15];
        entry_o.rs2 = instr_i[24:20];
        illegal     = !((funct7 == 7'd0) ||
                        (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)));
      end
      OPC_SYSTEM: begin
        if (funct3 == 3'b000) begin
          is_ecall  = (instr_i == 32'h0000_0073);
          is_ebreak = (instr_i == 32'h0010_0073);
          illegal   = !is_ecall && !is_ebreak;
        end else begin
          // CSR access, rs1 also carries the zimm of the immediate forms
          entry_o.fu  = FU_CSR;
          entry_o.rd  = instr_i[11:7];
          entry_o.rs1 = instr_i[19:15];
          entry_o.imm = {20'd0, instr_i[31:20]};
          illegal     = (funct3 == 3'b100);
        end
      end
      default: begin
        illegal = 1'b1;
      end
    endcase

    // Exception priority
    if (fetch_fault_i) begin
      entry_o.ex = '{valid: 1'b1, cause: CAUSE_FETCH_FAULT};
    end else if (illegal_i || illegal) begin
      entry_o.ex = '{valid: 1'b1, cause: CAUSE_ILLEGAL};
    end else if (is_ebreak) begin
      entry_o.ex = '{valid: 1'b1, cause: CAUSE_BREAKPOINT};
    end else if (is_ecall) begin
      entry_o.ex = '{valid: 1'b1, cause: CAUSE_ECALL_M};
    end
    if (entry_o.ex.valid) begin
      entry_o.fu = FU_NONE;
    end
  end

endmodule

`default_nettype wire

//--- verilog/fetch_queue.sv
// ----------------------------------------------------------
// Fetch queue
// Circular FIFO filled by credited pushes from fetch. Each
// popped entry returns one credit to fetch
// ----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module fetch_queue #(
  parameter int unsigned FETCH_DEPTH = 4
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,
  input  logic                 fetch_valid_i,
  input  id_pkg::fetch_entry_t fetch_entry_i,
  input  logic                 pop_i,
  output id_pkg::fetch_entry_t head_o,
  output logic                 head_valid_o,
  output logic                 fetch_credit_o
);

  import id_pkg::*;

  localparam int unsigned PW = (FETCH_DEPTH > 1) ? $clog2(FETCH_DEPTH) : 1;
  localparam int unsigned CW = $clog2(FETCH_DEPTH + 1);

  fetch_entry_t    mem_q [FETCH_DEPTH];
  logic [PW-1:0]   wr_ptr_q;
  logic [PW-1:0]   rd_ptr_q;
  logic [CW-1:0]   count_q;
  logic            push;
  logic            pop;

  assign push = fetch_valid_i && !flush_i;
  assign pop  = pop_i && head_valid_o && !flush_i;

  assign head_o         = mem_q[rd_ptr_q];
  assign head_valid_o   = (count_q != '0);
  assign fetch_credit_o = pop;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PW'(FETCH_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PW'(FETCH_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CW'(push) - CW'(pop);
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= fetch_entry_i;
    end
  end

endmodule

`default_nettype wire

//--- verilog/issue_port.sv
// ----------------------------------------------------------
// Issue port
// ID/issue pipeline register with a credit counter towards
// the issue unit. Sends one entry per credit
// ----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module issue_port #(
  parameter int unsigned ISSUE_CREDITS = 2
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,
  input  id_pkg::issue_entry_t entry_i,
  input  logic                 entry_valid_i,
  input  logic                 issue_credit_i,
  output logic                 pop_o,
  output logic                 issue_valid_o,
  output id_pkg::issue_entry_t issue_entry_o
);

  import id_pkg::*;

  localparam int unsigned CW = $clog2(ISSUE_CREDITS + 1);

  logic          valid_q;
  issue_entry_t  entry_q;
  logic [CW-1:0] credits_q;
  logic [CW-1:0] credits_left;
  logic          send;
  logic          load;

  // ----------------------------------------------------------
  // Send and load decisions
  // ----------------------------------------------------------
  assign send         = valid_q && (credits_q != '0) && !flush_i;
  // Credits that remain once this cycle's send is paid for
  assign credits_left = credits_q - CW'(send);
  assign load         = entry_valid_i && !flush_i && (!valid_q || send) &&
                        (credits_left != '0);

  assign pop_o         = load;
  assign issue_valid_o = send;
  assign issue_entry_o = entry_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= 1'b1;
    end else if (send) begin
      valid_q <= 1'b0;
    end
  end

  // Credits are kept across a flush
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credits_q <= CW'(ISSUE_CREDITS);
    end else begin
      credits_q <= credits_left + CW'(issue_credit_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      entry_q <= entry_i;
    end
  end

endmodule

`default_nettype wire

//--- verilog/id_stage_top.sv
// ----------------------------------------------------------
// Instruction decode stage
// Fetch queue, RVC expander, RV32I decoder and issue port
// between the fetch and issue units
// ----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module id_stage_top #(
  parameter int unsigned FETCH_DEPTH   = 4,
  parameter int unsigned ISSUE_CREDITS = 2
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,
  input  logic                 fetch_valid_i,
  input  id_pkg::fetch_entry_t fetch_entry_i,
  input  logic                 issue_credit_i,
  output logic                 fetch_credit_o,
  output logic                 issue_valid_o,
  output id_pkg::issue_entry_t issue_entry_o
);

  import id_pkg::*;

  fetch_entry_t head;
  logic         head_valid;
  logic         pop;
  logic [31:0]  expanded_instr;
  logic         is_compressed;
  logic         illegal_rvc;
  issue_entry_t decoded;

  fetch_queue #(
    .FETCH_DEPTH(FETCH_DEPTH)
  ) u_fetch_queue (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .fetch_valid_i (fetch_valid_i),
    .fetch_entry_i (fetch_entry_i),
    .pop_i         (pop),
    .head_o        (head),
    .head_valid_o  (head_valid),
    .fetch_credit_o(fetch_credit_o)
  );

  compressed_expander u_compressed_expander (
    .instr_i        (head.instr),
    .instr_o        (expanded_instr),
    .is_compressed_o(is_compressed),
    .illegal_o      (illegal_rvc)
  );

  instr_decoder u_instr_decoder (
    .pc_i           (head.pc),
    .instr_i        (expanded_instr),
    .orig_instr_i   (head.instr),
    .is_compressed_i(is_compressed),
    .illegal_i      (illegal_rvc),
    .fetch_fault_i  (head.fetch_fault),
    .entry_o        (decoded)
  );

  issue_port #(
    .ISSUE_CREDITS(ISSUE_CREDITS)
  ) u_issue_port (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .entry_i       (decoded),
    .entry_valid_i (head_valid),
    .issue_credit_i(issue_credit_i),
    .pop_o         (pop),
    .issue_valid_o (issue_valid_o),
    .issue_entry_o (issue_entry_o)
  );

endmodule

`default_nettype wire

//--- tests/tb_id_stage.sv
// ----------------------------------------------------------
// Decode stage testbench
// Fetch credit model, issue credit sink with random delays,
// reference decoder and expected queue, checked by assertions
// ----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module tb_id_stage;

  import id_pkg::*;

  localparam int FETCH_DEPTH   = 4;
  localparam int ISSUE_CREDITS = 2;
  localparam int WAIT_LIMIT    = 300;

  // Legal RV32I words, one per class
  localparam logic [31:0] RV32I_WORDS [12] = '{
    32'h1234_50b7, 32'hffff_f117, 32'hffdf_f0ef, 32'h0102_80e7,
    32'h0041_c863, 32'hff81_2303, 32'h0074_01a3, 32'hfff5_0493,
    32'h4036_5593, 32'h40f7_06b3, 32'h3001_10f3, 32'h0000_0013
  };

  // Supported RVC encodings, equivalents in rvc_equivalent()
  localparam logic [15:0] RVC_WORDS [12] = '{
    16'h0001, 16'h0515, 16'h55fd, 16'h660d, 16'ha021, 16'h8082,
    16'h829a, 16'h93a6, 16'h4044, 16'hc588, 16'hc011, 16'hfcfd
  };

  logic         clk_i;
  logic         rst_ni;
  logic         flush_i;
  logic         fetch_valid_i;
  fetch_entry_t fetch_entry_i;
  logic         issue_credit_i;
  logic         fetch_credit_o;
  logic         issue_valid_o;
  issue_entry_t issue_entry_o;

  issue_entry_t exp_q[$];
  issue_entry_t exp_head;
  logic [31:0]  next_pc;
  logic         sink_enable;
  int           fetch_credits;
  int           sink_owed;
  int           issued_cnt;
  int           returned_cnt;
  int           credit_pulses;
  int           errors;
  int           tests_run;
  int           tests_failed;

  id_stage_top #(
    .FETCH_DEPTH  (FETCH_DEPTH),
    .ISSUE_CREDITS(ISSUE_CREDITS)
  ) u_id_stage_top (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .fetch_valid_i (fetch_valid_i),
    .fetch_entry_i (fetch_entry_i),
    .issue_credit_i(issue_credit_i),
    .fetch_credit_o(fetch_credit_o),
    .issue_valid_o (issue_valid_o),
    .issue_entry_o (issue_entry_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // ----------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------
  // Hand-expanded 32-bit equivalents of the RVC table
  function automatic logic rvc_equivalent(input logic [15:0] h, output logic [31:0] w);
    w = 32'h0;
    case (h)
      16'h0001: w = 32'h0000_0013;  // nop
      16'h0515: w = 32'h0055_0513;  // addi x10, x10, 5
      16'h55fd: w = 32'hfff0_0593;  // addi x11, x0, -1
      16'h660d: w = 32'h0000_3637;  // lui x12, 3
      16'ha021: w = 32'h0080_006f;  // jal x0, 8
      16'h8082: w = 32'h0000_8067;  // jalr x0, 0(x1)
      16'h829a: w = 32'h0060_02b3;  // add x5, x0, x6
      16'h93a6: w = 32'h0093_83b3;  // add x7, x7, x9
      16'h4044: w = 32'h0044_2483;  // lw x9, 4(x8)
      16'hc588: w = 32'h00a5_a423;  // sw x10, 8(x11)
      16'hc011: w = 32'h0004_0263;  // beq x8, x0, 4
      16'hfcfd: w = 32'hfe04_9fe3;  // bne x9, x0, -2
      default: return 1'b0;
    endcase
    return 1'b1;
  endfunction

  function automatic issue_entry_t ref_decode(input fetch_entry_t fe);
    issue_entry_t e;
    logic [31:0]  w;
    logic         rvc_ok;
    logic         bad;
    logic [2:0]   f3;
    logic [6:0]   f7;
    e               = '0;
    e.pc            = fe.pc;
    e.orig_instr    = fe.instr;
    e.is_compressed = (fe.instr[1:0] != 2'b11);
    w               = fe.instr;
    rvc_ok          = 1'b1;
    if (e.is_compressed) begin
      rvc_ok = rvc_equivalent(fe.instr[15:0], w);
    end
    f3  = w[14:12];
    f7  = w[31:25];
    bad = 1'b0;
    case (w[6:0])
      OPC_LUI, OPC_AUIPC: begin
        e.fu  = FU_ALU;
        e.rd  = w[11:7];
        e.imm = {w[31:12], 12'h0};
      end
      OPC_JAL: begin
        e.fu           = FU_BRANCH;
        e.rd           = w[11:7];
        e.imm          = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        e.is_ctrl_flow = 1'b1;
      end
      OPC_JALR: begin
        e.fu           = FU_BRANCH;
        e.rd           = w[11:7];
        e.rs1          = w[19:15];
        e.imm          = {{20{w[31]}}, w[31:20]};
        e.is_ctrl_flow = 1'b1;
        bad            = (f3 != 3'd0);
      end
      OPC_BRANCH: begin
        e.fu           = FU_BRANCH;
        e.rs1          = w[19:15];
        e.rs2          = w[24:20];
        e.imm          = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        e.is_ctrl_flow = 1'b1;
        bad            = (f3 inside {3'd2, 3'd3});
      end
      OPC_LOAD: begin
        e.fu  = FU_LOAD;
        e.rd  = w[11:7];
        e.rs1 = w[19:15];
        e.imm = {{20{w[31]}}, w[31:20]};
        bad   = (f3 inside {3'd3, 3'd6, 3'd7});
      end
      OPC_STORE: begin
        e.fu  = FU_STORE;
        e.rs1 = w[19:15];
        e.rs2 = w[24:20];
        e.imm = {{20{w[31]}}, w[31:25], w[11:7]};
        bad   = (f3 > 3'd2);
      end
      OPC_OP_IMM: begin
        e.fu  = FU_ALU;
        e.rd  = w[11:7];
        e.rs1 = w[19:15];
        e.imm = {{20{w[31]}}, w[31:20]};
        bad   = (f3 == 3'd1 && f7 != 7'h00) || (f3 == 3'd5 && !(f7 inside {7'h00, 7'h20}));
      end
      OPC_OP: begin
        e.fu  = FU_ALU;
        e.rd  = w[11:7];
        e.rs1 = w[19:15];
        e.rs2 = w[24:20];
        bad   = !(f7 == 7'h00 || (f7 == 7'h20 && f3 inside {3'd0, 3'd5}));
      end
      OPC_SYSTEM: begin
        if (f3 == 3'd0) begin
          bad = !(w == 32'h0000_0073 || w == 32'h0010_0073);
        end else begin
          e.fu  = FU_CSR;
          e.rd  = w[11:7];
          e.rs1 = w[19:15];
          e.imm = {20'h0, w[31:20]};
          bad   = (f3 == 3'd4);
        end
      end
      default: bad = 1'b1;
    endcase
    if (fe.fetch_fault) begin
      e.ex = '{valid: 1'b1, cause: CAUSE_FETCH_FAULT};
    end else if (!rvc_ok || bad) begin
      e.ex = '{valid: 1'b1, cause: CAUSE_ILLEGAL};
    end else if (w == 32'h0010_0073) begin
      e.ex = '{valid: 1'b1, cause: CAUSE_BREAKPOINT};
    end else if (w == 32'h0000_0073) begin
      e.ex = '{valid: 1'b1, cause: CAUSE_ECALL_M};
    end
    if (e.ex.valid) begin
      e.fu = FU_NONE;
    end
    return e;
  endfunction

  // Operand fields of an excepting entry carry no meaning
  function automatic logic same_entry(input issue_entry_t got, input issue_entry_t exp);
    if (exp.ex.valid) begin
      return got.pc === exp.pc && got.orig_instr === exp.orig_instr && got.fu === exp.fu &&
             got.is_compressed === exp.is_compressed && got.ex === exp.ex;
    end
    return got === exp;
  endfunction

  // Decoded fields of one entry as text
  function automatic string entry_text(input issue_entry_t e);
    return $sformatf("fu %0d rd %0d rs1 %0d rs2 %0d imm %h ctrl %b ex %h", e.fu, e.rd,
                     e.rs1, e.rs2, e.imm, e.is_ctrl_flow, e.ex);
  endfunction

  function automatic logic [31:0] random_word();
    logic [31:0] r;
    r = $urandom;
    if (r[0]) begin
      return RV32I_WORDS[$urandom % 12];
    end
    return {r[31:16], RVC_WORDS[$urandom % 12]};
  endfunction

  // ----------------------------------------------------------
  // Issue monitor and credit bookkeeping
  // ----------------------------------------------------------
  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (fetch_credit_o) begin
        credit_pulses++;
        fetch_credits++;
      end
      if (issue_credit_i) begin
        returned_cnt++;
      end
      if (issue_valid_o) begin
        issued_cnt++;
        sink_owed++;
        if (exp_q.size() == 0) begin
          $display("Error: %0t: pc %h issued with no entry expected", $time,
                   issue_entry_o.pc);
          errors++;
        end else begin
          exp_head = exp_q.pop_front();
          a_issue_match: assert (same_entry(issue_entry_o, exp_head)) else begin
            $display("Error: %0t: pc %h instr %h got %s, expected pc %h %s", $time,
                     issue_entry_o.pc, issue_entry_o.orig_instr, entry_text(issue_entry_o),
                     exp_head.pc, entry_text(exp_head));
            errors++;
          end
        end
      end
    end
  end

  // Issue sink returns credits after random delays
  always @(negedge clk_i) begin
    if (sink_enable && sink_owed > 0 && ($urandom % 3) == 0) begin
      issue_credit_i = 1'b1;
      sink_owed--;
    end else begin
      issue_credit_i = 1'b0;
    end
  end

  a_issue_credit_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
      issue_valid_o |-> (issued_cnt < ISSUE_CREDITS + returned_cnt))
    else begin
      $display("Error: %0t: issue_valid_o without an issue credit", $time);
      errors++;
    end

  a_fetch_credit_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
      fetch_credits <= FETCH_DEPTH)
    else begin
      $display("Error: %0t: fetch holds %0d credits, more than the queue depth", $time,
               fetch_credits);
      errors++;
    end

  a_flush_quiet: assert property (@(posedge clk_i) disable iff (!rst_ni)
      flush_i |-> !issue_valid_o && !fetch_credit_o ##1 !issue_valid_o)
    else begin
      $display("Error: %0t: issue or credit activity around a flush", $time);
      errors++;
    end

  // ----------------------------------------------------------
  // Stimulus tasks
  // ----------------------------------------------------------
  task automatic push_word(input logic [31:0] word, input logic fault);
    fetch_entry_t fe;
    int           waited;
    waited = 0;
    while (fetch_credits == 0 && waited < WAIT_LIMIT) begin
      @(negedge clk_i);
      waited++;
    end
    if (fetch_credits == 0) begin
      $display("Timeout: fetch got no credit back within %0d cycles", WAIT_LIMIT);
      errors++;
    end else begin
      fe            = '{pc: next_pc, instr: word, fetch_fault: fault};
      fetch_valid_i = 1'b1;
      fetch_entry_i = fe;
      fetch_credits--;
      exp_q.push_back(ref_decode(fe));
      next_pc = next_pc + 32'd4;
      @(negedge clk_i);
      fetch_valid_i = 1'b0;
    end
  endtask

  task automatic drain(input string what);
    int waited;
    waited = 0;
    while ((exp_q.size() != 0 || sink_owed != 0) && waited < WAIT_LIMIT) begin
      @(negedge clk_i);
      waited++;
    end
    if (exp_q.size() != 0 || sink_owed != 0) begin
      $display("Timeout: %s still waits for %0d entries after %0d cycles", what,
               exp_q.size(), WAIT_LIMIT);
      errors++;
    end
    // Last returned credit lands on the next edge
    @(negedge clk_i);
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    a_count: assert (got == exp) else begin
      $display("Error: %0t: %s is %0d, expected %0d", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic end_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("Test %s passed", name);
    end else begin
      tests_failed++;
      $display("Test %s failed with %0d errors", name, errors - errors_before);
    end
  endtask

  // ----------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------
  initial begin
    int err0;
    int issued0;
    int credits0;
    $timeformat(-9, 0, " ns", 0);
    void'($urandom(32'hc103_079d));
    rst_ni         = 1'b0;
    flush_i        = 1'b0;
    fetch_valid_i  = 1'b0;
    fetch_entry_i  = '0;
    issue_credit_i = 1'b0;
    sink_enable    = 1'b1;
    next_pc        = 32'h0000_1000;
    fetch_credits  = FETCH_DEPTH;
    sink_owed      = 0;
    issued_cnt     = 0;
    returned_cnt   = 0;
    credit_pulses  = 0;
    errors         = 0;
    tests_run      = 0;
    tests_failed   = 0;
    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;

    err0 = errors;
    repeat (3) begin
      @(negedge clk_i);
      a_reset_quiet: assert (!issue_valid_o && !fetch_credit_o) else begin
        $display("Error: %0t: output active after reset", $time);
        errors++;
      end
    end
    end_test("reset", err0);

    // Every RV32I class in push order
    err0     = errors;
    issued0  = issued_cnt;
    credits0 = credit_pulses;
    for (int i = 0; i < 12; i++) begin
      push_word(RV32I_WORDS[i], 1'b0);
    end
    drain("rv32i");
    check_count("issued rv32i entries", issued_cnt - issued0, 12);
    check_count("fetch credits for rv32i", credit_pulses - credits0, 12);
    end_test("rv32i", err0);

    err0     = errors;
    issued0  = issued_cnt;
    credits0 = credit_pulses;
    for (int i = 0; i < 12; i++) begin
      push_word({16'h0, RVC_WORDS[i]}, 1'b0);
    end
    drain("compressed");
    check_count("issued compressed entries", issued_cnt - issued0, 12);
    check_count("fetch credits for compressed", credit_pulses - credits0, 12);
    end_test("compressed", err0);

    err0 = errors;
    push_word(32'h0000_0000, 1'b0);
    push_word(32'h0000_6105, 1'b0);
    push_word(32'h0000_9002, 1'b0);
    push_word(32'h0000_007f, 1'b0);
    push_word(32'h0200_0033, 1'b0);
    push_word(32'h0010_0073, 1'b0);
    push_word(32'h0000_0073, 1'b0);
    push_word(32'h0000_007f, 1'b1);
    push_word(32'h0000_0000, 1'b1);
    push_word(32'h0000_0073, 1'b1);
    drain("exceptions");
    end_test("exceptions", err0);

    err0     = errors;
    issued0  = issued_cnt;
    credits0 = credit_pulses;
    repeat (40) begin
      push_word(random_word(), 1'b0);
      repeat ($urandom % 4) @(negedge clk_i);
    end
    drain("random bursts");
    check_count("issued burst entries", issued_cnt - issued0, 40);
    check_count("fetch credits for bursts", credit_pulses - credits0, 40);
    check_count("fetch credits held", fetch_credits, FETCH_DEPTH);
    end_test("random_bursts", err0);

    // Withheld credits stall the register, then the queue, then fetch
    err0        = errors;
    issued0     = issued_cnt;
    credits0    = credit_pulses;
    sink_enable = 1'b0;
    repeat (6) begin
      push_word(random_word(), 1'b0);
    end
    repeat (20) @(negedge clk_i);
    check_count("issued while stalled", issued_cnt - issued0, ISSUE_CREDITS);
    check_count("entries held", exp_q.size(), FETCH_DEPTH);
    check_count("fetch credits while stalled", fetch_credits, 0);
    sink_enable = 1'b1;
    drain("back pressure");
    check_count("issued after release", issued_cnt - issued0, 6);
    check_count("fetch credits after release", credit_pulses - credits0, 6);
    end_test("back_pressure", err0);

    err0        = errors;
    sink_enable = 1'b0;
    repeat (6) begin
      push_word(random_word(), 1'b0);
    end
    repeat (5) @(negedge clk_i);
    flush_i       = 1'b1;
    exp_q.delete();
    fetch_credits = FETCH_DEPTH;
    @(negedge clk_i);
    flush_i     = 1'b0;
    sink_enable = 1'b1;
    // New address range so a stale entry cannot match
    next_pc = 32'h8000_0000;
    issued0 = issued_cnt;
    repeat (8) begin
      push_word(random_word(), 1'b0);
    end
    drain("flush");
    check_count("issued after flush", issued_cnt - issued0, 8);
    check_count("fetch credits after flush", fetch_credits, FETCH_DEPTH);
    end_test("flush", err0);

    $display("Tests run: %0d, passed: %0d, failed: %0d, errors: %0d", tests_run,
             tests_run - tests_failed, tests_failed, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- id_stage.f
common/id_pkg.sv
decode/compressed_expander.sv
decode/instr_decoder.sv
verilog/fetch_queue.sv
verilog/issue_port.sv
verilog/id_stage_top.sv
tests/tb_id_stage.sv

//--- Bender.yml
package:
  name: id_stage

sources:
  # Shared types
  - common/id_pkg.sv
  # Decode logic
  - decode/compressed_expander.sv
  - decode/instr_decoder.sv
  # Queue, issue port and top level
  - verilog/fetch_queue.sv
  - verilog/issue_port.sv
  - verilog/id_stage_top.sv
  - target: test
    files:
      - tests/tb_id_stage.sv
